// File: hdl/rv_pkg.sv
package rv_pkg;

	////////////////////////////////////////////////////////////////////////////
	// major opcodes.
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_auipc  = 7'b0010111;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_opimm  = 7'b0010011;
	localparam logic [6:0] op_op     = 7'b0110011;
	localparam logic [6:0] op_system = 7'b1110011;
	localparam logic [6:0] op_fence  = 7'b0001111;

	////////////////////////////////////////////////////////////////////////////
	// bit positions in the one-hot opcode type.
	localparam int inst_lui   = 0;
	localparam int inst_auipc = 1;
	localparam int inst_jal   = 2;
	localparam int inst_jalr  = 3;
	localparam int inst_beq   = 4;
	localparam int inst_lw    = 5;
	localparam int inst_sw    = 6;
	localparam int inst_addi  = 7;
	localparam int inst_add   = 8;
	localparam int inst_csr   = 9;
	localparam int n_inst     = 10;

	// instruction formats.
	localparam int type_r = 0;
	localparam int type_i = 1;
	localparam int type_s = 2;
	localparam int type_b = 3;
	localparam int type_u = 4;
	localparam int type_j = 5;

	////////////////////////////////////////////////////////////////////////////
	localparam logic [11:0] csr_mstatus = 12'h300;
	localparam logic [11:0] csr_mtvec   = 12'h305;
	localparam logic [11:0] csr_mepc    = 12'h341;
	localparam logic [11:0] csr_mcause  = 12'h342;

	localparam logic [31:0] cause_ecall = 32'd11; // environment call from m-mode.
	localparam logic [31:0] reset_pc    = 32'h8000_0000;

endpackage

// File: hdl/rv_idu.sv
`timescale 1ns/100ps

module rv_idu (
	input  logic [31:0]               inst,
	input  logic                      valid,
	output logic [rv_pkg::n_inst-1:0] opcode_type,
	output logic [2:0]                funct3,
	output logic [6:0]                funct7,
	output logic [3:0]                rd,
	output logic [3:0]                rs1,
	output logic [3:0]                rs2,
	output logic [31:0]               imm,
	output logic                      lsu_wen,
	output logic                      lsu_ren,
	output logic                      reg_wen,
	output logic                      csr_enable,
	output logic                      inst_fencei
);

	logic [5:0] fmt;
	logic [6:0] opcode;

	assign opcode = inst[6:0];
	assign rd     = inst[10:7];  // upper register bit ignored, rv32e.
	assign rs1    = inst[18:15];
	assign rs2    = inst[23:20];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	////////////////////////////////////////////////////////////////////////////
	assign opcode_type[rv_pkg::inst_lui]   = (opcode == rv_pkg::op_lui);
	assign opcode_type[rv_pkg::inst_auipc] = (opcode == rv_pkg::op_auipc);
	assign opcode_type[rv_pkg::inst_jal]   = (opcode == rv_pkg::op_jal);
	assign opcode_type[rv_pkg::inst_jalr]  = (opcode == rv_pkg::op_jalr);
	assign opcode_type[rv_pkg::inst_beq]   = (opcode == rv_pkg::op_branch);
	assign opcode_type[rv_pkg::inst_lw]    = (opcode == rv_pkg::op_load);
	assign opcode_type[rv_pkg::inst_sw]    = (opcode == rv_pkg::op_store);
	assign opcode_type[rv_pkg::inst_addi]  = (opcode == rv_pkg::op_opimm);
	assign opcode_type[rv_pkg::inst_add]   = (opcode == rv_pkg::op_op);
	assign opcode_type[rv_pkg::inst_csr]   = (opcode == rv_pkg::op_system);
	assign inst_fencei = (opcode == rv_pkg::op_fence);

	assign fmt[rv_pkg::type_r] = opcode_type[rv_pkg::inst_add];
	assign fmt[rv_pkg::type_i] = opcode_type[rv_pkg::inst_jalr] | opcode_type[rv_pkg::inst_lw] |
		opcode_type[rv_pkg::inst_addi] | opcode_type[rv_pkg::inst_csr];
	assign fmt[rv_pkg::type_s] = opcode_type[rv_pkg::inst_sw];
	assign fmt[rv_pkg::type_b] = opcode_type[rv_pkg::inst_beq];
	assign fmt[rv_pkg::type_u] = opcode_type[rv_pkg::inst_lui] | opcode_type[rv_pkg::inst_auipc];
	assign fmt[rv_pkg::type_j] = opcode_type[rv_pkg::inst_jal];

	// sign-extended immediate per format.
	always_comb begin
		if (fmt[rv_pkg::type_i])
			imm = {{20{inst[31]}}, inst[31:20]};
		else if (fmt[rv_pkg::type_u])
			imm = {inst[31:12], 12'b0};
		else if (fmt[rv_pkg::type_s])
			imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
		else if (fmt[rv_pkg::type_j])
			imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
		else if (fmt[rv_pkg::type_b])
			imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
		else
			imm = 32'b0;
	end

	////////////////////////////////////////////////////////////////////////////
	assign lsu_ren = opcode_type[rv_pkg::inst_lw] & valid;
	assign lsu_wen = opcode_type[rv_pkg::inst_sw] & valid;

	// ecall and mret write no register. x0 is never a target.
	assign reg_wen = (fmt[rv_pkg::type_i] & ~((funct3 == 3'b0) & opcode_type[rv_pkg::inst_csr]) |
		fmt[rv_pkg::type_u] | fmt[rv_pkg::type_j] | fmt[rv_pkg::type_r]) & (rd != 4'd0);
	assign csr_enable = opcode_type[rv_pkg::inst_csr] & (funct3 != 3'b0);

endmodule

// File: hdl/rv_regfile.sv
`timescale 1ns/100ps

module rv_regfile (
	input  logic        clock,
	input  logic        rst,
	input  logic [3:0]  rs1,
	input  logic [3:0]  rs2,
	input  logic [3:0]  rd,
	input  logic        wen,
	input  logic [31:0] wdata,
	output logic [31:0] rdata1,
	output logic [31:0] rdata2
);

	logic [31:0] regs [16];

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < 16; i++) begin
				regs[i] <= 32'd0;
			end
		end else if (wen && rd != 4'd0) begin
			regs[rd] <= wdata;
		end
	end

	assign rdata1 = (rs1 == 4'd0) ? 32'd0 : regs[rs1];
	assign rdata2 = (rs2 == 4'd0) ? 32'd0 : regs[rs2];

	// decoder drops writes to x0 before they get here.
	assert property (@(posedge clock) disable iff (rst)
		!(wen && rd == 4'd0 && wdata != 32'd0));

endmodule

// File: hdl/rv_exu.sv
`timescale 1ns/100ps

module rv_exu (
	input  logic [31:0]               pc,
	input  logic [31:0]               src1,
	input  logic [31:0]               src2,
	input  logic [31:0]               imm,
	input  logic [rv_pkg::n_inst-1:0] opcode_type,
	output logic [31:0]               result,
	output logic [31:0]               mem_addr,
	output logic [31:0]               next_pc
);

	logic [31:0] pc_plus4;
	logic [31:0] pc_imm;
	logic [31:0] src1_imm;
	logic        beq_taken;

	assign pc_plus4 = pc + 32'd4;
	assign pc_imm   = pc + imm;     // auipc, jal and branch target.
	assign src1_imm = src1 + imm;   // addi, jalr and load/store.

	assign mem_addr  = src1_imm;
	assign beq_taken = opcode_type[rv_pkg::inst_beq] && (src1 == src2);

	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		if (opcode_type[rv_pkg::inst_lui])
			result = imm;
		else if (opcode_type[rv_pkg::inst_auipc])
			result = pc_imm;
		else if (opcode_type[rv_pkg::inst_jal] || opcode_type[rv_pkg::inst_jalr])
			result = pc_plus4;  // link address.
		else if (opcode_type[rv_pkg::inst_add])
			result = src1 + src2;
		else
			result = src1_imm;
	end

	always_comb begin
		if (opcode_type[rv_pkg::inst_jal] || beq_taken)
			next_pc = pc_imm;
		else if (opcode_type[rv_pkg::inst_jalr])
			next_pc = {src1_imm[31:1], 1'b0};
		else
			next_pc = pc_plus4;
	end

endmodule

// File: hdl/rv_csr.sv
`timescale 1ns/100ps

module rv_csr (
	input  logic        clock,
	input  logic        rst,
	input  logic        commit,
	input  logic        csr_enable,
	input  logic [2:0]  funct3,
	input  logic [6:0]  funct7,
	input  logic [11:0] csr_addr,
	input  logic [31:0] src1,
	input  logic [31:0] pc,
	output logic [31:0] rdata,
	output logic        trap,
	output logic [31:0] trap_pc
);

	logic [31:0] mstatus;
	logic [31:0] mtvec;
	logic [31:0] mepc;
	logic [31:0] mcause;
	logic [31:0] wval;
	logic        is_ecall;
	logic        is_mret;

	always_comb begin
		case (csr_addr)
			rv_pkg::csr_mstatus: rdata = mstatus;
			rv_pkg::csr_mtvec:   rdata = mtvec;
			rv_pkg::csr_mepc:    rdata = mepc;
			rv_pkg::csr_mcause:  rdata = mcause;
			default:             rdata = 32'd0;
		endcase
	end

	assign wval     = funct3[1] ? (rdata | src1) : src1; // csrrs sets, csrrw replaces.
	assign is_ecall = (funct3 == 3'b0) && (funct7 == 7'b0000000);
	assign is_mret  = (funct3 == 3'b0) && (funct7 == 7'b0011000);
	assign trap     = commit & (is_ecall | is_mret);
	assign trap_pc  = is_mret ? mepc : mtvec;

	always_ff @(posedge clock) begin
		if (rst) begin
			mstatus <= 32'd0;
			mtvec   <= 32'd0;
			mepc    <= 32'd0;
			mcause  <= 32'd0;
		end else if (commit && csr_enable) begin
			case (csr_addr)
				rv_pkg::csr_mstatus: mstatus <= wval;
				rv_pkg::csr_mtvec:   mtvec   <= wval;
				rv_pkg::csr_mepc:    mepc    <= wval;
				rv_pkg::csr_mcause:  mcause  <= wval;
				default: ;
			endcase
		end else if (commit && is_ecall) begin
			mepc   <= pc;
			mcause <= rv_pkg::cause_ecall;
		end
	end

endmodule

// File: hdl/rv_apb_master.sv
`timescale 1ns/100ps

module rv_apb_master (
	input  logic        clock,
	input  logic        rst,
	input  logic        req,
	input  logic        we,
	input  logic [31:0] addr,
	input  logic [31:0] wdata,
	input  logic [31:0] prdata,
	input  logic        pready,
	output logic        done,
	output logic [31:0] rdata,
	output logic        psel,
	output logic        penable,
	output logic        pwrite,
	output logic [31:0] paddr,
	output logic [31:0] pwdata
);

	typedef enum logic [1:0] {st_idle, st_setup, st_access} state_t;

	state_t state;

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= st_idle;
			done  <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				st_idle:   if (req) state <= st_setup;
				st_setup:  state <= st_access;
				st_access: begin
					if (pready) begin
						state <= st_idle;
						done  <= 1'b1; // one cycle after completion.
					end
				end
				default:   state <= st_idle;
			endcase
		end
	end

	// request held for the whole transfer.
	always_ff @(posedge clock) begin
		if (state == st_idle && req) begin
			pwrite <= we;
			paddr  <= addr;
			pwdata <= wdata;
		end
		if (state == st_access && pready)
			rdata <= prdata;
	end

	assign psel    = (state != st_idle);
	assign penable = (state == st_access);

	////////////////////////////////////////////////////////////////////////////
	assert property (@(posedge clock) disable iff (rst) penable |-> psel);
	assert property (@(posedge clock) disable iff (rst)
		(penable && !pready) |=> $stable(paddr));

endmodule

// File: hdl/rv_ctrl.sv
`timescale 1ns/100ps

module rv_ctrl (
	input  logic        clock,
	input  logic        rst,
	input  logic        done,
	input  logic [31:0] rdata,
	input  logic        lsu_wen,
	input  logic        lsu_ren,
	input  logic        reg_wen,
	input  logic        csr_enable,
	input  logic        trap,
	input  logic [31:0] trap_pc,
	input  logic [31:0] next_pc,
	input  logic [31:0] result,
	input  logic [31:0] mem_addr,
	input  logic [31:0] src2,
	input  logic [31:0] csr_rdata,
	output logic        req,
	output logic        we,
	output logic [31:0] addr,
	output logic [31:0] wdata,
	output logic [31:0] pc,
	output logic [31:0] inst,
	output logic        inst_valid,
	output logic        rf_wen,
	output logic [31:0] rf_wdata,
	output logic        commit
);

	typedef enum logic [1:0] {s_fetch, s_exec, s_mem, s_wb} state_t;

	state_t state;

	always_ff @(posedge clock) begin
		if (rst) begin
			state <= s_fetch;
			pc    <= rv_pkg::reset_pc;
		end else begin
			case (state)
				s_fetch: if (done) state <= s_exec;
				s_exec:  state <= (lsu_wen || lsu_ren) ? s_mem : s_wb;
				s_mem:   if (done) state <= s_wb;
				s_wb: begin
					pc    <= trap ? trap_pc : next_pc;
					state <= s_fetch;
				end
				default: state <= s_fetch;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (state == s_fetch && done)
			inst <= rdata;
	end

	////////////////////////////////////////////////////////////////////////////
	assign inst_valid = (state != s_fetch);
	assign req   = (state == s_fetch || state == s_mem) && !done; // held until done.
	assign we    = (state == s_mem) && lsu_wen;
	assign addr  = (state == s_mem) ? mem_addr : pc;
	assign wdata = src2;

	// write-back source.
	assign commit   = (state == s_wb);
	assign rf_wen   = commit & reg_wen;
	assign rf_wdata = lsu_ren ? rdata : csr_enable ? csr_rdata : result;

	// a transfer completes only while the sequencer waits for one.
	assert property (@(posedge clock) disable iff (rst)
		done |-> (state == s_fetch || state == s_mem));

endmodule

// File: hdl/rv_core.sv
`timescale 1ns/100ps

module rv_core (
	input  logic        clock,
	input  logic        rst,
	input  logic [31:0] prdata,
	input  logic        pready,
	output logic        psel,
	output logic        penable,
	output logic        pwrite,
	output logic [31:0] paddr,
	output logic [31:0] pwdata
);

	logic                      req, we, done, commit, sys_commit;
	logic [31:0]               addr, wdata, bus_rdata;
	logic [31:0]               pc, inst, imm, result, mem_addr, next_pc;
	logic                      inst_valid, rf_wen;
	logic [31:0]               rf_wdata, src1, src2, csr_rdata, trap_pc;
	logic [rv_pkg::n_inst-1:0] opcode_type;
	logic [2:0]                funct3;
	logic [6:0]                funct7;
	logic [3:0]                rd, rs1, rs2;
	logic                      lsu_wen, lsu_ren, reg_wen, csr_enable, trap;

	// only system instructions reach the csr block.
	assign sys_commit = commit & opcode_type[rv_pkg::inst_csr];

	////////////////////////////////////////////////////////////////////////////
	rv_ctrl u_ctrl (
		.clock(clock), .rst(rst), .done(done), .rdata(bus_rdata),
		.lsu_wen(lsu_wen), .lsu_ren(lsu_ren), .reg_wen(reg_wen), .csr_enable(csr_enable),
		.trap(trap), .trap_pc(trap_pc), .next_pc(next_pc), .result(result),
		.mem_addr(mem_addr), .src2(src2), .csr_rdata(csr_rdata),
		.req(req), .we(we), .addr(addr), .wdata(wdata), .pc(pc), .inst(inst),
		.inst_valid(inst_valid), .rf_wen(rf_wen), .rf_wdata(rf_wdata), .commit(commit));

	rv_idu u_idu (
		.inst(inst), .valid(inst_valid), .opcode_type(opcode_type),
		.funct3(funct3), .funct7(funct7), .rd(rd), .rs1(rs1), .rs2(rs2), .imm(imm),
		.lsu_wen(lsu_wen), .lsu_ren(lsu_ren), .reg_wen(reg_wen),
		.csr_enable(csr_enable), .inst_fencei());  // fence.i retires as a no-op.

	rv_regfile u_regfile (
		.clock(clock), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd),
		.wen(rf_wen), .wdata(rf_wdata), .rdata1(src1), .rdata2(src2));

	rv_exu u_exu (
		.pc(pc), .src1(src1), .src2(src2), .imm(imm), .opcode_type(opcode_type),
		.result(result), .mem_addr(mem_addr), .next_pc(next_pc));

	rv_csr u_csr (
		.clock(clock), .rst(rst), .commit(sys_commit), .csr_enable(csr_enable),
		.funct3(funct3), .funct7(funct7), .csr_addr(imm[11:0]), .src1(src1), .pc(pc),
		.rdata(csr_rdata), .trap(trap), .trap_pc(trap_pc));

	rv_apb_master u_apb (
		.clock(clock), .rst(rst), .req(req), .we(we), .addr(addr), .wdata(wdata),
		.prdata(prdata), .pready(pready), .done(done), .rdata(bus_rdata),
		.psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata));

endmodule

// File: tests/rv_model.svh
////////////////////////////////////////////////////////////////////////////
// random program generator.
logic [31:0] rng;
int          pidx;
logic [31:0] mm [2048];   // model copy of memory.
logic [31:0] m_x [16];
logic [31:0] m_csr [4];   // mstatus, mtvec, mepc, mcause.
logic [31:0] m_pc;

function automatic logic [31:0] next_rand();
	rng = rng * 32'd1664525 + 32'd1013904223;
	return rng ^ (rng >> 15);
endfunction

function automatic logic [3:0] rand_reg(); // x14 and x15 stay reserved.
	logic [31:0] r;
	r = next_rand() % 32'd13 + 32'd1;
	return r[3:0];
endfunction

function automatic logic [31:0] enc_i(logic [6:0] op, logic [3:0] rd, logic [2:0] f3,
	logic [3:0] rs1, logic [11:0] imm);
	return {imm, 1'b0, rs1, f3, 1'b0, rd, op};
endfunction

function automatic logic [31:0] enc_s(logic [3:0] rs1, logic [3:0] rs2, logic [11:0] imm);
	return {imm[11:5], 1'b0, rs2, 1'b0, rs1, 3'b010, imm[4:0], rv_pkg::op_store};
endfunction

task automatic put(logic [31:0] w);
	mem[pidx] = w;
	pidx++;
endtask

task automatic gen_program();
	logic [31:0] r;
	logic [3:0]  a;
	logic [3:0]  b;
	logic [31:0] fill_inst;
	pidx = 512; // trap handler, steps mepc past the ecall.
	put(enc_i(rv_pkg::op_system, 4'd14, 3'b010, 4'd0, rv_pkg::csr_mepc));
	put(enc_i(rv_pkg::op_opimm, 4'd14, 3'b000, 4'd14, 12'd4));
	put(enc_i(rv_pkg::op_system, 4'd0, 3'b001, 4'd14, rv_pkg::csr_mepc));
	put(32'h3020_0073);
	pidx = 0;
	put({data_base[31:12], 1'b0, 4'd15, rv_pkg::op_lui});
	put({data_base[31:12], 1'b0, 4'd14, rv_pkg::op_lui});
	put(enc_i(rv_pkg::op_opimm, 4'd14, 3'b000, 4'd14, 12'h800)); // handler address.
	put(enc_i(rv_pkg::op_system, 4'd0, 3'b001, 4'd14, rv_pkg::csr_mtvec));
	for (int k = 1; k < 14; k++) begin
		r = next_rand();
		put(enc_i(rv_pkg::op_opimm, k[3:0], 3'b000, 4'd0, r[11:0]));
	end
	while (pidx < prog_len) begin
		r = next_rand();
		a = rand_reg();
		b = rand_reg();
		fill_inst = enc_i(rv_pkg::op_opimm, b, 3'b000, b, 12'd1);
		case (r % 32'd10)
			0: put({8'd0, b, 1'b0, a, 3'b000, 1'b0, rand_reg(), rv_pkg::op_op});
			1: put(enc_i(rv_pkg::op_opimm, a, 3'b000, b, r[31:20]));
			2: put({r[31:12], 1'b0, a, rv_pkg::op_auipc});
			3: put(enc_i(rv_pkg::op_load, a, 3'b010, 4'd15, {4'b0, r[18:13], 2'b00}));
			4: put(enc_s(4'd15, a, {4'b0, r[18:13], 2'b00}));
			5: begin // beq over one word.
				put({8'd0, r[20] ? a : b, 1'b0, a, 3'b000, 4'b0100, 1'b0, rv_pkg::op_branch});
				put(fill_inst);
			end
			6: begin
				put({1'b0, 10'd4, 1'b0, 8'd0, 1'b0, a, rv_pkg::op_jal});
				put(fill_inst);
			end
			7: begin
				put({20'd0, 1'b0, 4'd14, rv_pkg::op_auipc});
				put(enc_i(rv_pkg::op_jalr, a, 3'b000, 4'd14, 12'd12));
				put(fill_inst);
			end
			8: begin
				if (r[22:21] == 2'd3)
					put(enc_i(rv_pkg::op_system, a, 3'b010, 4'd0, rv_pkg::csr_mtvec));
				else
					put(enc_i(rv_pkg::op_system, a, r[20] ? 3'b010 : 3'b001, b,
						r[22] ? rv_pkg::csr_mcause :
						r[21] ? rv_pkg::csr_mepc : rv_pkg::csr_mstatus));
			end
			default: put(r[20] ? 32'h0000_0073 : 32'h0000_100f); // ecall or fence.i.
		endcase
	end
	for (int k = 1; k < 16; k++)
		put(enc_s(4'd15, k[3:0], 12'd128 + {k[9:0], 2'b00}));
	put({20'h80002, 1'b0, 4'd14, rv_pkg::op_lui});
	put(enc_s(4'd14, 4'd0, 12'hffc)); // end marker.
endtask

////////////////////////////////////////////////////////////////////////////
// reference model, one instruction per call.
function automatic int csr_slot(logic [11:0] a);
	case (a)
		rv_pkg::csr_mstatus: return 0;
		rv_pkg::csr_mtvec:   return 1;
		rv_pkg::csr_mepc:    return 2;
		default:             return 3;
	endcase
endfunction

task automatic set_reg(logic [3:0] rd, logic [31:0] v);
	if (rd != 4'd0)
		m_x[rd] = v;
endtask

task automatic model_step();
	logic [31:0] w;
	logic [31:0] a;
	logic [31:0] iv;
	logic [31:0] nxt;
	logic [31:0] old;
	logic [31:0] ea;
	int          slot;
	w = mm[widx(m_pc)];
	a = m_x[w[18:15]];
	iv = {{20{w[31]}}, w[31:20]};
	nxt = m_pc + 32'd4;
	expect_xfer(m_pc, 1'b0, 32'd0);
	case (w[6:0])
		rv_pkg::op_lui:   set_reg(w[10:7], {w[31:12], 12'b0});
		rv_pkg::op_auipc: set_reg(w[10:7], m_pc + {w[31:12], 12'b0});
		rv_pkg::op_jal: begin
			set_reg(w[10:7], m_pc + 32'd4);
			nxt = m_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
		end
		rv_pkg::op_jalr: begin
			nxt = (a + iv) & ~32'd1;
			set_reg(w[10:7], m_pc + 32'd4);
		end
		rv_pkg::op_branch:
			if (a == m_x[w[23:20]])
				nxt = m_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
		rv_pkg::op_load: begin
			expect_xfer(a + iv, 1'b0, 32'd0);
			set_reg(w[10:7], mm[widx(a + iv)]);
		end
		rv_pkg::op_store: begin
			ea = a + {{20{w[31]}}, w[31:25], w[11:7]};
			expect_xfer(ea, 1'b1, m_x[w[23:20]]);
			mm[widx(ea)] = m_x[w[23:20]];
		end
		rv_pkg::op_opimm: set_reg(w[10:7], a + iv);
		rv_pkg::op_op:    set_reg(w[10:7], a + m_x[w[23:20]]);
		rv_pkg::op_system: begin
			if (w[14:12] != 3'b000) begin
				slot = csr_slot(w[31:20]);
				old = m_csr[slot];
				m_csr[slot] = w[13] ? (old | a) : a;
				set_reg(w[10:7], old);
			end else if (w[31:25] == 7'b0011000) begin
				nxt = m_csr[2];
			end else begin
				m_csr[2] = m_pc;
				m_csr[3] = rv_pkg::cause_ecall;
				nxt = m_csr[1];
			end
		end
		default: ;
	endcase
	m_pc = nxt;
endtask

// File: tests/tb_core.sv
`timescale 1ns/100ps

module tb_core;

	localparam logic [31:0] seed        = 32'h5ada0f60;
	localparam logic [31:0] data_base   = 32'h8000_1000;
	localparam logic [31:0] end_addr    = 32'h8000_1ffc;
	localparam int          prog_len    = 150;
	localparam int          max_wait    = 3;
	localparam int          cycle_limit = 12000;

	logic        clock, rst, pready, psel, penable, pwrite;
	logic [31:0] prdata, paddr, pwdata;
	logic [31:0] mem [2048];
	logic [31:0] exp_addr [$];
	logic        exp_we [$];
	logic [31:0] exp_data [$];
	logic [31:0] held_addr, held_data, sig, zero_wait_sig;
	logic        held_we, random_wait, finished;
	int          errors, cycles, wait_cnt, xfers, clean;

	function automatic logic [10:0] widx(logic [31:0] a);
		return a[12:2];
	endfunction

	task automatic expect_xfer(logic [31:0] a, logic we, logic [31:0] d);
		exp_addr.push_back(a);
		exp_we.push_back(we);
		exp_data.push_back(d);
	endtask

	`include "rv_model.svh"

	rv_core dut (
		.clock(clock), .rst(rst), .prdata(prdata), .pready(pready), .psel(psel),
		.penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata));

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles >= cycle_limit) begin
			$display("timeout: run stopped after %0d cycles without finishing", cycles);
			$display("test failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// APB memory, checks each completed transfer against the model.
	task automatic complete_transfer();
		if (!finished) begin
			if (exp_addr.size() == 0)
				model_step();
			if (paddr != exp_addr[0] || pwrite != exp_we[0] ||
				(pwrite && pwdata != exp_data[0])) begin
				$display("FAIL %0t: got %h we %b data %h, expected %h we %b data %h", $time,
					paddr, pwrite, pwdata, exp_addr[0], exp_we[0], exp_data[0]);
				errors++;
			end
			void'(exp_addr.pop_front());
			void'(exp_we.pop_front());
			void'(exp_data.pop_front());
			if (pwrite) begin
				mem[widx(paddr)] = pwdata;
				sig = {sig[26:0], sig[31:27]} ^ paddr ^ pwdata;
				finished = (paddr == end_addr);
			end
			xfers++;
		end
	endtask

	always @(posedge clock) begin : responder
		logic [31:0] w;
		if (rst) begin
			pready <= 1'b0;
		end else begin
			if (penable && !psel) begin
				$display("bus error at %0t: penable high without psel", $time);
				errors++;
			end
			if (penable && (paddr != held_addr || pwrite != held_we || pwdata != held_data)) begin
				$display("bus error at %0t: request changed before pready", $time);
				errors++;
			end
			if (psel && !penable) begin
				w = random_wait ? next_rand() % (max_wait + 1) : 32'd0;
				held_addr <= paddr;
				held_we   <= pwrite;
				held_data <= pwdata;
				wait_cnt  <= w;
				pready    <= (w == 32'd0);
				prdata    <= mem[widx(paddr)];
			end else if (penable && !pready) begin
				wait_cnt <= wait_cnt - 1;
				pready   <= (wait_cnt == 1);
			end else if (penable && pready) begin
				pready <= 1'b0;
				complete_transfer();
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	task automatic run_test(int t);
		int err0;
		err0 = errors;
		@(posedge clock);
		rst <= 1'b1;
		@(posedge clock); // responder sits in reset from here.
		rng = seed ^ (32'h9e37_79b9 * (t / 2)); // same program for both runs of a pair.
		random_wait = t[0];
		for (int i = 0; i < 2048; i++)
			mem[i] = {19'h40000, i[10:0], 2'b00} ^ {i[15:0], 16'h3c5a} ^ 32'h5a5a_0f0f;
		gen_program();
		mm = mem;
		m_pc = rv_pkg::reset_pc;
		m_x = '{default: 32'd0};
		m_csr = '{default: 32'd0};
		exp_addr.delete();
		exp_we.delete();
		exp_data.delete();
		finished = 1'b0;
		sig = 32'd0;
		xfers = 0;
		repeat (4) @(posedge clock);
		rst <= 1'b0;
		@(posedge clock);
		if (psel || penable) begin
			$display("FAIL %0t: bus selects high after reset", $time);
			errors++;
		end
		while (!finished) @(posedge clock);
		if (!random_wait)
			zero_wait_sig = sig;
		else if (sig != zero_wait_sig) begin
			$display("write stream with wait states differs from the zero-wait run");
			errors++;
		end
		if (errors == err0)
			clean++;
		$display("program %0d, %s waits: %0d transfers, %0d errors", t / 2,
			random_wait ? "random" : "no", xfers, errors - err0);
	endtask

	initial begin
		rst = 1'b1;
		pready = 1'b0;
		prdata = 32'd0;
		random_wait = 1'b0;
		finished = 1'b0;
		errors = 0;
		cycles = 0;
		clean = 0;
		for (int t = 0; t < 4; t++)
			run_test(t);
		$display("%0d of 4 tests clean, %0d errors", clean, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// File: src.f
+incdir+tests
hdl/rv_pkg.sv
hdl/rv_idu.sv
hdl/rv_regfile.sv
hdl/rv_exu.sv
hdl/rv_csr.sv
hdl/rv_apb_master.sv
hdl/rv_ctrl.sv
hdl/rv_core.sv
tests/tb_core.sv

// File: run.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_core -f src.f -o tb_core
./obj_dir/tb_core | tee sim.log

if grep -q "test failed" sim.log; then
	echo "simulation reported a failure"
	exit 1
fi
